// File: hdl/retire_pkg.sv
// XLEN is fixed at 32 and memory words at 64; error codes keep the RISC-V cause encodings
package retire_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] xlen_t;     // address or data word
	typedef logic [4:0]      reg_idx_t;  // index 0 is the zero register
	typedef logic [63:0]     bus_data_t; // one memory beat
	typedef logic [1:0]      way_idx_t;

	localparam reg_idx_t ZERO_REG = '0;

	////////////////////////////////////////////////////////////////////////////
	// encodings

	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_e;

	typedef enum logic [1:0] {
		BYTE   = 2'h0,
		HALF   = 2'h1,
		WORD   = 2'h2,
		DOUBLE = 2'h3  // instruction fetches always use this
	} mem_size_e;

	// cause numbers as in the trap encoding, NO_ERROR and halt picked from the spare codes
	typedef enum logic [3:0] {
		ILLEGAL_INST      = 4'h2,
		LOAD_ACCESS_FAULT = 4'h5,
		NO_ERROR          = 4'ha,
		HALTED_ON_WFI     = 4'he
	} error_e;

	////////////////////////////////////////////////////////////////////////////
	// bundles

	// one way leaving execute/memory
	typedef struct packed {
		xlen_t     npc;
		xlen_t     alu_result;
		reg_idx_t  dest_reg;
		logic      halt;
		logic      illegal;
		logic      valid;      // clear means bubble
		bus_cmd_e  mem_cmd;
		xlen_t     mem_addr;
		xlen_t     mem_data;   // store data
		mem_size_e mem_size;
	} exmem_t;

	// register file write plus the npc of the retiring instruction
	typedef struct packed {
		logic     wr_en;
		reg_idx_t wr_idx;
		xlen_t    wr_data;
		xlen_t    npc;
	} commit_t;

	typedef struct packed {
		bus_cmd_e  cmd;
		xlen_t     addr;
		bus_data_t data;
		mem_size_e size;
	} mem_req_t;

	typedef struct packed {
		logic     take;
		way_idx_t way; // ways above this one are squashed
	} branch_t;

endpackage

// File: hdl/lane_commit.sv
// mem/wb register for every way; loads commit the low word of mem_data, no size or sign handling
`timescale 1ns/1ps

module lane_commit import retire_pkg::*; #(
	parameter int ways = 3
) (
	input  logic            clock,
	input  logic            reset,
	input  exmem_t          bundle [ways],
	input  bus_data_t       mem_data [ways],
	input  branch_t         branch,
	output commit_t         commit [ways],
	output logic [ways-1:0] committed,
	output logic [ways-1:0] halted,
	output logic [ways-1:0] illegal
);

	logic [ways-1:0] keep;           // way is not younger than a taken branch
	xlen_t           result [ways];  // value headed for the register file

	////////////////////////////////////////////////////////////////////////////
	// squash mask and result select

	always_comb begin
		for (int w = 0; w < ways; w++) begin
			keep[w] = !branch.take || (w <= int'(branch.way));
			if (bundle[w].mem_cmd == BUS_LOAD)
				result[w] = mem_data[w][XLEN-1:0]; // low word only
			else
				result[w] = bundle[w].alu_result;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// mem/wb register

	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int w = 0; w < ways; w++)
				commit[w] <= '0;
			committed <= '0;
			halted    <= '0;
			illegal   <= '0;
		end else begin
			for (int w = 0; w < ways; w++) begin
				if (keep[w]) begin
					commit[w] <= '{
						wr_en:   bundle[w].valid && (bundle[w].dest_reg != ZERO_REG),
						wr_idx:  bundle[w].dest_reg,
						wr_data: result[w],
						npc:     bundle[w].npc
					};
					committed[w] <= bundle[w].valid;
					halted[w]    <= bundle[w].halt;    // raw flag, as the bundle carries it
					illegal[w]   <= bundle[w].illegal;
				end else begin
					// younger than the branch, becomes a bubble
					commit[w]    <= '0;
					committed[w] <= 1'b0;
					halted[w]    <= 1'b0;
					illegal[w]   <= 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks

	for (genvar w = 0; w < ways; w++) begin : g_chk
		// squashed way must not reach the register file one cycle later
		assert property (@(posedge clock) disable iff (!reset)
			(branch.take && (w > int'(branch.way))) |=> !commit[w].wr_en);
	end

endmodule

// File: hdl/mem_port_arbiter.sv
// one request per way each cycle, data access wins over fetch; memory must answer in the same cycle
`timescale 1ns/1ps

module mem_port_arbiter import retire_pkg::*; #(
	parameter int ways = 3
) (
	input  logic            clock,
	input  logic            reset,
	input  exmem_t          bundle [ways],
	input  xlen_t           fetch_addr [ways],
	input  logic [3:0]      response [ways],
	output mem_req_t        request [ways],
	output logic [ways-1:0] fault
);

	mem_req_t next_req [ways];

	////////////////////////////////////////////////////////////////////////////
	// data vs fetch select

	always_comb begin
		for (int w = 0; w < ways; w++) begin
			if (bundle[w].mem_cmd != BUS_NONE) begin
				next_req[w] = '{
					cmd:  bundle[w].mem_cmd,
					addr: bundle[w].mem_addr,
					data: bus_data_t'(bundle[w].mem_data), // zero extended
					size: bundle[w].mem_size
				};
			end else begin
				// no data access, the port fetches instructions
				next_req[w] = '{
					cmd:  BUS_LOAD,
					addr: fetch_addr[w],
					data: '0,
					size: DOUBLE
				};
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// request and fault registers

	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int w = 0; w < ways; w++)
				request[w] <= '{cmd: BUS_LOAD, addr: '0, data: '0, size: DOUBLE};
			fault <= '0;
		end else begin
			for (int w = 0; w < ways; w++) begin
				request[w] <= next_req[w];
				fault[w]   <= (response[w] == 4'h0); // tag 0 means memory refused
			end
		end
	end

	for (genvar w = 0; w < ways; w++) begin : g_chk
		// the port always carries a load or a store
		assert property (@(posedge clock) disable iff (!reset)
			request[w].cmd != BUS_NONE);
	end

endmodule

// File: hdl/retire_status.sv
// count is combinational on the commit flags; status is sticky until reset
`timescale 1ns/1ps

module retire_status import retire_pkg::*; #(
	parameter int ways = 3
) (
	input  logic            clock,
	input  logic            reset,
	input  logic [ways-1:0] committed,
	input  logic [ways-1:0] halted,
	input  logic [ways-1:0] illegal,
	input  logic [ways-1:0] fault,
	output logic [2:0]      completed,
	output error_e          status
);

	error_e status_next;

	always_comb begin
		completed = 3'd0;
		for (int w = 0; w < ways; w++)
			completed = completed + 3'(committed[w]); // each way counted once
	end

	////////////////////////////////////////////////////////////////////////////
	// sticky status, priority illegal > halt > fault

	always_comb begin
		status_next = status;
		if (status == NO_ERROR) begin
			if (|illegal)
				status_next = ILLEGAL_INST;
			else if (|halted)
				status_next = HALTED_ON_WFI;
			else if (|fault)
				status_next = LOAD_ACCESS_FAULT;
		end
	end

	always_ff @(posedge clock) begin
		if (!reset)
			status <= NO_ERROR;
		else
			status <= status_next;
	end

	// once an error is latched nothing in any way may overwrite it
	assert property (@(posedge clock) disable iff (!reset)
		(status != NO_ERROR) |=> $stable(status));

endmodule

// File: hdl/retire_pipe.sv
// retire and memory port block; ways from 1 to 4, no handshake, every cycle is accepted
`timescale 1ns/1ps

module retire_pipe import retire_pkg::*; #(
	parameter int ways = 3
) (
	input  logic       clock,
	input  logic       reset,
	input  exmem_t     bundle [ways],
	input  xlen_t      fetch_addr [ways],
	input  branch_t    branch,
	input  logic [3:0] mem_response [ways],
	input  bus_data_t  mem_data [ways],
	output commit_t    commit [ways],
	output mem_req_t   mem_request [ways],
	output logic [2:0] completed,
	output error_e     status
);

	// flags from the mem/wb register
	logic [ways-1:0] committed;
	logic [ways-1:0] halted;
	logic [ways-1:0] illegal;
	logic [ways-1:0] fault;    // from the memory port

	////////////////////////////////////////////////////////////////////////////
	// commit side

	lane_commit #(
		.ways(ways)
	) lane_commit_0 (
		.clock     (clock),
		.reset     (reset),
		.bundle    (bundle),
		.mem_data  (mem_data),
		.branch    (branch),
		.commit    (commit),
		.committed (committed),
		.halted    (halted),
		.illegal   (illegal)
	);

	////////////////////////////////////////////////////////////////////////////
	// memory side

	mem_port_arbiter #(
		.ways(ways)
	) mem_port_arbiter_0 (
		.clock      (clock),
		.reset      (reset),
		.bundle     (bundle),
		.fetch_addr (fetch_addr),
		.response   (mem_response),
		.request    (mem_request),
		.fault      (fault)
	);

	retire_status #(
		.ways(ways)
	) retire_status_0 (
		.clock     (clock),
		.reset     (reset),
		.committed (committed),
		.halted    (halted),
		.illegal   (illegal),
		.fault     (fault),
		.completed (completed),
		.status    (status)
	);

endmodule

// File: test/tb_clock.sv
// clock starts low at time 0; reset is held low for reset_cycles rising edges at start and after restart
`timescale 1ns/1ps

module tb_clock #(
	parameter int half_period  = 50, // ns
	parameter int reset_cycles = 2
) (
	input  logic restart, // sampled on the rising edge
	output logic clock,
	output logic reset
);

	int left; // low edges still to come

	initial begin
		clock = 1'b0;
		reset <= 1'b0;
		left  <= reset_cycles;
		forever #half_period clock = ~clock;
	end

	always @(posedge clock) begin
		if (restart) begin
			reset <= 1'b0;
			left  <= reset_cycles;
		end else if (left > 1) begin
			left <= left - 1;
		end else if (left == 1) begin
			left  <= 0;
			reset <= 1'b1; // last low edge done
		end
	end

endmodule

// File: test/tb_retire_pipe.sv
// ways fixed at 3; the DUT status is sticky, so each status case ends with a fresh reset
`timescale 1ns/1ps

module tb_retire_pipe import retire_pkg::*; ();

	localparam int ways            = 3;
	localparam int random_cycles   = 400;
	localparam int directed_cycles = 80; // about 60 used
	localparam int cycle_limit     = 2 + directed_cycles + random_cycles + 18;

	// inputs as the DUT saw them at one rising edge
	typedef struct packed {
		logic                 reset;
		exmem_t [ways-1:0]    bundle;
		xlen_t [ways-1:0]     fetch_addr;
		branch_t              branch;
		logic [ways-1:0][3:0] response;
		bus_data_t [ways-1:0] mem_data;
	} sample_t;

	typedef struct packed {
		commit_t [ways-1:0]  commits;
		mem_req_t [ways-1:0] requests;
		logic [2:0]          completed;
		error_e              status;
	} expect_t;

	logic       clock;
	logic       reset;
	logic       restart;
	exmem_t     bundle [ways];
	xlen_t      fetch_addr [ways];
	branch_t    branch;
	logic [3:0] mem_response [ways];
	bus_data_t  mem_data [ways];
	commit_t    commit [ways];
	mem_req_t   mem_request [ways];
	logic [2:0] completed;
	error_e     status;

	int      seed        = 74062;
	int      cycles      = 0;
	int      errors      = 0;
	string   test_name   = "reset";
	string   last_name   = "reset";
	sample_t last_sample = '0; // inputs at the latest edge
	sample_t prev_sample = '0; // one edge earlier
	logic    started     = 1'b0;
	error_e  exp_status  = NO_ERROR;

	tb_clock #(
		.half_period  (50),
		.reset_cycles (2)
	) clock_gen (
		.restart (restart),
		.clock   (clock),
		.reset   (reset)
	);

	retire_pipe #(
		.ways(ways)
	) DUT (
		.clock        (clock),
		.reset        (reset),
		.bundle       (bundle),
		.fetch_addr   (fetch_addr),
		.branch       (branch),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.commit       (commit),
		.mem_request  (mem_request),
		.completed    (completed),
		.status       (status)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model

	function automatic expect_t predict(sample_t now, sample_t prev, error_e last);
		expect_t         e;
		logic            kept;
		logic [ways-1:0] ill;
		logic [ways-1:0] hlt;
		logic [ways-1:0] flt;
		e = '0;
		for (int w = 0; w < ways; w++) begin
			kept = !now.branch.take || (w <= int'(now.branch.way));
			if (now.reset && kept) begin
				e.commits[w].wr_en  = now.bundle[w].valid && (now.bundle[w].dest_reg != 5'd0);
				e.commits[w].wr_idx = now.bundle[w].dest_reg;
				e.commits[w].npc    = now.bundle[w].npc;
				if (now.bundle[w].mem_cmd == BUS_LOAD)
					e.commits[w].wr_data = now.mem_data[w][31:0]; // load keeps the low word
				else
					e.commits[w].wr_data = now.bundle[w].alu_result;
				if (now.bundle[w].valid)
					e.completed = e.completed + 3'd1;
			end
			if (now.reset && (now.bundle[w].mem_cmd != BUS_NONE)) begin
				e.requests[w].cmd  = now.bundle[w].mem_cmd;
				e.requests[w].addr = now.bundle[w].mem_addr;
				e.requests[w].data = {32'h0, now.bundle[w].mem_data};
				e.requests[w].size = now.bundle[w].mem_size;
			end else begin
				// fetch, also the reset value with address 0
				e.requests[w].cmd  = BUS_LOAD;
				e.requests[w].addr = now.reset ? now.fetch_addr[w] : 32'h0;
				e.requests[w].size = DOUBLE;
			end
			// flags registered one edge before, seen by the status now
			kept   = !prev.branch.take || (w <= int'(prev.branch.way));
			ill[w] = prev.reset && kept && prev.bundle[w].illegal;
			hlt[w] = prev.reset && kept && prev.bundle[w].halt;
			flt[w] = prev.reset && (prev.response[w] == 4'h0);
		end
		if (!now.reset)
			e.status = NO_ERROR;
		else if (last != NO_ERROR)
			e.status = last; // held until reset
		else if (|ill)
			e.status = ILLEGAL_INST;
		else if (|hlt)
			e.status = HALTED_ON_WFI;
		else if (|flt)
			e.status = LOAD_ACCESS_FAULT;
		else
			e.status = NO_ERROR;
		return e;
	endfunction

	function automatic sample_t capture_inputs();
		sample_t s;
		s.reset  = reset;
		s.branch = branch;
		for (int w = 0; w < ways; w++) begin
			s.bundle[w]     = bundle[w];
			s.fetch_addr[w] = fetch_addr[w];
			s.response[w]   = mem_response[w];
			s.mem_data[w]   = mem_data[w];
		end
		return s;
	endfunction

	task automatic check(input string name, input logic [159:0] expected,
			input logic [159:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// history and comparison

	always @(posedge clock) begin
		prev_sample <= last_sample;
		last_sample <= capture_inputs();
		last_name   <= test_name;
		started     <= 1'b1;
	end

	always @(negedge clock) begin
		expect_t e;
		if (started) begin
			e = predict(last_sample, prev_sample, exp_status);
			exp_status = e.status;
			for (int w = 0; w < ways; w++) begin
				check($sformatf("%s commit[%0d]", last_name, w),
					160'(e.commits[w]), 160'(commit[w]));
				check($sformatf("%s mem_request[%0d]", last_name, w),
					160'(e.requests[w]), 160'(mem_request[w]));
			end
			check($sformatf("%s completed", last_name), 160'(e.completed), 160'(completed));
			check($sformatf("%s status", last_name), 160'(e.status), 160'(status));
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Errors found");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers

	function automatic exmem_t alu_op(xlen_t npc, reg_idx_t rd, xlen_t value);
		exmem_t b;
		b            = '0;
		b.npc        = npc;
		b.alu_result = value;
		b.dest_reg   = rd;
		b.valid      = 1'b1;
		b.mem_cmd    = BUS_NONE;
		b.mem_size   = WORD;
		return b;
	endfunction

	function automatic exmem_t mem_op(bus_cmd_e cmd, xlen_t npc, reg_idx_t rd, xlen_t addr,
			xlen_t data, mem_size_e size);
		exmem_t b;
		b          = alu_op(npc, rd, 32'h0);
		b.mem_cmd  = cmd;
		b.mem_addr = addr;
		b.mem_data = data;
		b.mem_size = size;
		return b;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
	endtask

	task automatic set_idle();
		for (int w = 0; w < ways; w++) begin
			bundle[w]       <= '0; // bubble, no memory command
			fetch_addr[w]   <= 32'h0000_1000 + 32'(w * 8);
			mem_response[w] <= 4'h1;
			mem_data[w]     <= '0;
		end
		branch <= '0;
	endtask

	task automatic wait_for_reset();
		next_cycle();
		while (!reset)
			next_cycle();
	endtask

	task automatic restart_reset();
		set_idle();
		restart <= 1'b1;
		next_cycle();
		restart <= 1'b0;
		next_cycle();
		while (!reset)
			next_cycle();
	endtask

	// flags for one cycle, later every condition at once, which must not move the status
	task automatic error_case(input logic [ways-1:0] ill, input logic [ways-1:0] hlt,
			input logic [ways-1:0] flt, input branch_t br);
		exmem_t b;
		set_idle();
		for (int w = 0; w < ways; w++) begin
			b         = alu_op(32'h0000_3000 + 32'(w * 4), reg_idx_t'(w + 1), 32'h77);
			b.illegal = ill[w];
			b.halt    = hlt[w];
			bundle[w] <= b;
			if (flt[w])
				mem_response[w] <= 4'h0;
		end
		branch <= br;
		next_cycle();
		set_idle();
		repeat (2) next_cycle();
		for (int w = 0; w < ways; w++) begin
			b               = alu_op(32'h0000_3100 + 32'(w * 4), reg_idx_t'(w + 9), 32'h88);
			b.illegal       = 1'b1;
			b.halt          = 1'b1;
			bundle[w]       <= b;
			mem_response[w] <= 4'h0;
		end
		next_cycle();
		set_idle();
		repeat (2) next_cycle();
		restart_reset();
	endtask

	task automatic randomize_inputs();
		exmem_t     b;
		logic [31:0] r;
		logic [1:0]  pick;
		for (int w = 0; w < ways; w++) begin
			r            = $random(seed);
			b.npc        = $random(seed);
			b.alu_result = $random(seed);
			b.dest_reg   = r[4:0];
			b.valid      = r[5];
			b.halt       = (r[17:8] == 10'h0);  // about 1 in 1024
			b.illegal    = (r[27:18] == 10'h0);
			pick         = (r[29:28] == 2'd3) ? 2'd0 : r[29:28];
			b.mem_cmd    = bus_cmd_e'(pick);
			b.mem_size   = mem_size_e'(r[31:30]);
			b.mem_addr   = $random(seed);
			b.mem_data   = $random(seed);
			bundle[w]     <= b;
			fetch_addr[w] <= $random(seed);
			mem_data[w]   <= {$random(seed), $random(seed)};
			r = $random(seed);
			mem_response[w] <= (r[9:0] == 10'h0) ? 4'h0 : {r[13:11], 1'b1};
		end
		r = $random(seed);
		branch <= '{take: (r[1:0] == 2'b00), way: r[3:2]};
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		exmem_t b;
		restart <= 1'b0;
		set_idle();
		wait_for_reset();
		repeat (2) next_cycle(); // reset values only

		test_name <= "commit";
		bundle[0] <= alu_op(32'h0000_0104, 5'd1, 32'hdead_0001);
		bundle[1] <= alu_op(32'h0000_0108, 5'd2, 32'hdead_0002);
		bundle[2] <= alu_op(32'h0000_010c, 5'd31, 32'hdead_0003);
		next_cycle();
		bundle[0] <= alu_op(32'h0000_0110, 5'd3, 32'h1111_2222);
		bundle[1] <= alu_op(32'h0000_0114, 5'd0, 32'h3333_4444); // zero register
		b       = alu_op(32'h0000_0118, 5'd4, 32'h5555_6666);
		b.valid = 1'b0;
		bundle[2] <= b;
		next_cycle();
		bundle[0]   <= mem_op(BUS_LOAD, 32'h0000_011c, 5'd5, 32'h0000_8000, 32'h0, WORD);
		bundle[1]   <= mem_op(BUS_STORE, 32'h0000_0120, 5'd0, 32'h0000_8008, 32'hcafe_f00d, WORD);
		bundle[2]   <= mem_op(BUS_LOAD, 32'h0000_0124, 5'd7, 32'h0000_8010, 32'h0, DOUBLE);
		mem_data[0] <= 64'h1234_5678_9abc_def0;
		mem_data[1] <= 64'h0bad_0bad_0bad_0bad; // store, not committed
		mem_data[2] <= 64'hffff_0000_5555_aaaa;
		next_cycle();
		set_idle();
		next_cycle();

		test_name <= "squash";
		for (int k = 0; k < 5; k++) begin
			for (int w = 0; w < ways; w++)
				bundle[w] <= alu_op(32'h0000_0200 + 32'(k * 16 + w * 4), reg_idx_t'(8 + w),
					32'(k * 100 + w));
			branch <= '{take: (k < 4), way: way_idx_t'(k)}; // way 3 squashes nothing
			next_cycle();
		end

		set_idle();
		test_name     <= "memreq";
		bundle[0]     <= mem_op(BUS_STORE, 32'h0000_0300, 5'd0, 32'h0000_9000, 32'h8000_0001, DOUBLE);
		bundle[1]     <= mem_op(BUS_LOAD, 32'h0000_0304, 5'd6, 32'h0000_9002, 32'h0, HALF);
		fetch_addr[2] <= 32'h0000_2040;
		next_cycle();
		set_idle();
		for (int w = 0; w < ways; w++)
			fetch_addr[w] <= 32'h0000_4000 + 32'(w * 32);
		next_cycle();
		for (int w = 0; w < ways; w++)
			bundle[w] <= mem_op(BUS_STORE, 32'h0000_0310, 5'd0, 32'h0000_a001 + 32'(w),
				32'hffff_ff00 + 32'(w), BYTE);
		next_cycle();
		set_idle();
		next_cycle();

		test_name <= "status";
		error_case(3'b000, 3'b000, 3'b010, '0);                      // fault alone
		error_case(3'b000, 3'b100, 3'b001, '0);                      // halt over fault
		error_case(3'b010, 3'b001, 3'b100, '0);                      // illegal over both
		error_case(3'b100, 3'b001, 3'b000, '{take: 1'b1, way: 2'd1}); // squashed illegal

		test_name <= "random";
		for (int i = 0; i < random_cycles; i++) begin
			randomize_inputs();
			next_cycle();
		end
		set_idle();
		repeat (3) next_cycle();

		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: compile.f
hdl/retire_pkg.sv
hdl/lane_commit.sv
hdl/mem_port_arbiter.sv
hdl/retire_status.sv
hdl/retire_pipe.sv
test/tb_clock.sv
test/tb_retire_pipe.sv

// File: Makefile
TOP = tb_retire_pipe

.PHONY: all lint clean

# build, run, then decide on the log
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qx "No errors" sim.log

obj_dir/V$(TOP): compile.f hdl/*.sv test/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f

lint:
	verilator --lint-only -Wall --timing --top-module retire_pipe \
		hdl/retire_pkg.sv \
		hdl/lane_commit.sv \
		hdl/mem_port_arbiter.sv \
		hdl/retire_status.sv \
		hdl/retire_pipe.sv

clean:
	rm -rf obj_dir sim.log
